//--- mix_engine.f
logic/mix_pkg.sv
logic/mix_ctrl_if.sv
logic/mix_step_unit.sv
logic/mix_core.sv
logic/mix_apb_regs.sv
logic/mix_engine.sv
verification/mix_engine_chk.sv
verification/mix_engine_tb.sv

//--- verification/mix_engine_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mix_engine_tb
    import mix_pkg::*;
();

    localparam int MIX_ROUNDS   = 16;
    localparam int CHAIN_ROUNDS = 12;
    localparam int PROG_LEN     = 3 + 3 * MIX_ROUNDS + CHAIN_ROUNDS;
    // Twenty runs with APB overhead at an 8 ns period, doubled for margin
    localparam int WATCHDOG_NS  = 20 * (PROG_LEN + 40) * 8 * 2;

    typedef struct {
        string name;
        bit    is_flag;
        word_t exp;
        word_t act;
    } cmp_t;

    logic                  clk;
    logic                  arst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    word_t                 pwdata;
    word_t                 prdata;
    logic                  pready;
    logic                  pslverr;

    cmp_t cmp_q[$];
    int   err_count   = 0;
    int   slverr_seen = 0;
    int   seed        = 32'h6963;

    mix_engine dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Lanes are rewritten in place from 0 to 7, so later lanes see earlier results
    function automatic lanes_t ref_mix(lanes_t s, int mix_rounds, int chain_rounds);
        lanes_t x;
        x = s;
        for (int i = 0; i < 8; i++) x[i] += i;
        for (int i = 0; i < 8; i++) x[i] += x[(i + 7) & 7];
        for (int r = 0; r < mix_rounds; r++) begin
            for (int i = 0; i < 8; i++) x[i] = x[i] + x[(i + 1) & 7] - x[(i + 5) & 7];
            for (int i = 0; i < 8; i++) x[i] ^= x[(i + 3) & 7] << 16;
            for (int i = 0; i < 8; i++) begin
                x[i] = x[i] - (x[(i + 2) & 7] >> 17) + (x[(i + 4) & 7] >> 12);
            end
        end
        for (int r = 0; r < chain_rounds; r++) begin
            for (int i = 0; i < 8; i++) x[i] = x[i] + x[(i + 7) & 7] - x[(i + 6) & 7];
        end
        // Each scaling only touches its own lane
        for (int i = 0; i < 8; i++) begin
            x[i] = x[i] * SCALE_A_MUL[i] + SCALE_A_ADD[i];
            x[i] = x[i] * SCALE_B_MUL[i] + SCALE_B_ADD[i];
        end
        return x;
    endfunction

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            err_count++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            err_count++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic void expect_word(string name, word_t exp, word_t act);
        cmp_q.push_back('{name, 1'b0, exp, act});
    endfunction

    function automatic void expect_flag(string name, logic exp, logic act);
        cmp_q.push_back('{name, 1'b1, word_t'(exp), word_t'(act)});
    endfunction

    // Setup phase, then access phase; outputs are sampled mid access phase
    task automatic apb_access(string name, logic wr, logic [APB_ADDR_W-1:0] addr,
                              word_t wdata, logic exp_err, output word_t rdata);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        expect_flag({name, " pready"}, 1'b1, pready);
        expect_flag({name, " pslverr"}, exp_err, pslverr);
        if (pslverr) begin
            slverr_seen++;
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(string name, logic [APB_ADDR_W-1:0] addr, word_t data,
                             logic exp_err);
        word_t unused;
        apb_access(name, 1'b1, addr, data, exp_err, unused);
    endtask

    task automatic apb_read(string name, logic [APB_ADDR_W-1:0] addr, logic exp_err,
                            output word_t data);
        apb_access(name, 1'b0, addr, '0, exp_err, data);
    endtask

    task automatic load_seed(string name, lanes_t s);
        for (int i = 0; i < LANES; i++) begin
            apb_write({name, " seed"}, SEED_BASE + APB_ADDR_W'(4 * i), s[i], 1'b0);
        end
    endtask

    task automatic check_lanes(string name, logic [APB_ADDR_W-1:0] base, lanes_t exp);
        word_t rd;
        for (int i = 0; i < LANES; i++) begin
            apb_read(name, base + APB_ADDR_W'(4 * i), 1'b0, rd);
            expect_word($sformatf("%s lane %0d", name, i), exp[i], rd);
        end
    endtask

    task automatic wait_done();
        word_t st;
        st = '0;
        while (st[1] !== 1'b1) apb_read("status poll", STATUS_ADDR, 1'b0, st);
    endtask

    task automatic run_and_check(string name, lanes_t s);
        load_seed(name, s);
        apb_write({name, " start"}, CTRL_ADDR, 32'd1, 1'b0);
        wait_done();
        check_lanes(name, RESULT_BASE, ref_mix(s, MIX_ROUNDS, CHAIN_ROUNDS));
    endtask

    initial begin : compare
        cmp_t c;
        forever begin
            wait (cmp_q.size() != 0);
            c = cmp_q.pop_front();
            if (c.is_flag) begin
                check_flag(c.name, c.exp[0], c.act[0]);
            end else begin
                check_word(c.name, c.exp, c.act);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        lanes_t s;
        lanes_t prev;
        word_t  rd;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        apb_read("reset status", STATUS_ADDR, 1'b0, rd);
        expect_word("reset status", '0, rd);
        check_lanes("reset result", RESULT_BASE, '{default: '0});

        for (int i = 0; i < LANES; i++) s[i] = word_t'(i);
        run_and_check("count seed", s);
        for (int r = 0; r < 10; r++) begin
            for (int i = 0; i < LANES; i++) s[i] = $random(seed);
            run_and_check($sformatf("random %0d", r), s);
        end

        // Writes during a run are refused and leave seed and result alone
        for (int i = 0; i < LANES; i++) s[i] = $random(seed);
        load_seed("busy", s);
        apb_write("busy start", CTRL_ADDR, 32'd1, 1'b0);
        apb_write("ctrl while busy", CTRL_ADDR, 32'd1, 1'b1);
        apb_write("seed while busy", SEED_BASE, 32'hdead_beef, 1'b1);
        wait_done();
        prev = ref_mix(s, MIX_ROUNDS, CHAIN_ROUNDS);
        check_lanes("busy result", RESULT_BASE, prev);
        check_lanes("busy seed readback", SEED_BASE, s);

        apb_read("unmapped 0x28", 8'h28, 1'b1, rd);
        expect_word("unmapped 0x28", '0, rd);
        apb_read("unmapped 0x62", 8'h62, 1'b1, rd);
        expect_word("unmapped 0x62", '0, rd);
        apb_write("result write", RESULT_BASE + 8'h04, 32'h1234_5678, 1'b1);
        apb_write("status write", STATUS_ADDR, 32'h3, 1'b1);
        check_lanes("after bad writes", RESULT_BASE, prev);

        // A restart clears done, and the previous result stays until the new one lands
        s[0] = s[0] + 32'd1;
        load_seed("restart", s);
        apb_write("restart start", CTRL_ADDR, 32'd1, 1'b0);
        apb_read("status running", STATUS_ADDR, 1'b0, rd);
        expect_word("status running", 32'h1, rd);
        apb_read("old result", RESULT_BASE, 1'b0, rd);
        expect_word("old result", prev[0], rd);
        wait_done();
        apb_read("status finished", STATUS_ADDR, 1'b0, rd);
        expect_word("status finished", 32'h2, rd);
        check_lanes("restart result", RESULT_BASE, ref_mix(s, MIX_ROUNDS, CHAIN_ROUNDS));

        wait (cmp_q.size() == 0);
        @(posedge clk);
        $display("Errors: %0d, pslverr responses: %0d", err_count, slverr_seen);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/mix_engine_chk.sv
`timescale 1ns/10ps
`default_nettype none

module mix_engine_chk (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic psel,
    input wire logic penable,
    input wire logic pready,
    input wire logic pslverr,
    input wire logic eng_busy,
    input wire logic done_bit,
    input wire logic start
);

    assert property (@(posedge clk) disable iff (!arst_n) pready)
        else $error("pready went low");

    assert property (@(posedge clk) disable iff (!arst_n) pslverr |-> psel && penable)
        else $error("pslverr raised outside an access phase");

    assert property (@(posedge clk) disable iff (!arst_n) !(eng_busy && done_bit))
        else $error("busy and done set at the same time");

    // A start is only accepted from an idle engine
    assert property (@(posedge clk) disable iff (!arst_n) start |-> !$past(eng_busy))
        else $error("start pulsed while the engine was busy");

endmodule

bind mix_apb_regs mix_engine_chk u_chk (
    .clk      (clk),
    .arst_n   (arst_n),
    .psel     (psel),
    .penable  (penable),
    .pready   (pready),
    .pslverr  (pslverr),
    .eng_busy (eng_busy),
    .done_bit (done_q),
    .start    (start_q)
);

`default_nettype wire

//--- logic/mix_engine.sv
`timescale 1ns/10ps
`default_nettype none

module mix_engine
    import mix_pkg::*;
#(
    parameter int MIX_ROUNDS   = 16,
    parameter int CHAIN_ROUNDS = 12
) (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  psel,
    input  wire logic                  penable,
    input  wire logic                  pwrite,
    input  wire logic [APB_ADDR_W-1:0] paddr,
    input  wire word_t                 pwdata,
    output word_t                      prdata,
    output logic                       pready,
    output logic                       pslverr
);

    mix_ctrl_if ctrl_bus ();

    mix_apb_regs u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ctrl    (ctrl_bus.regs)
    );

    mix_core #(
        .MIX_ROUNDS   (MIX_ROUNDS),
        .CHAIN_ROUNDS (CHAIN_ROUNDS)
    ) u_core (
        .clk    (clk),
        .arst_n (arst_n),
        .ctrl   (ctrl_bus.core)
    );

endmodule

`default_nettype wire

//--- logic/mix_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module mix_apb_regs
    import mix_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  psel,
    input  wire logic                  penable,
    input  wire logic                  pwrite,
    input  wire logic [APB_ADDR_W-1:0] paddr,
    input  wire word_t                 pwdata,
    output word_t                      prdata,
    output logic                       pready,
    output logic                       pslverr,
    mix_ctrl_if.regs                   ctrl
);

    localparam int IDX_W   = $clog2(LANES);
    localparam int WIN_LSB = IDX_W + 2;

    lanes_t            seed_q;
    lanes_t            result_q;
    logic              start_q;
    logic              done_q;
    logic              eng_busy;
    logic              access;
    logic              aligned;
    logic              seed_sel;
    logic              ctrl_sel;
    logic              status_sel;
    logic              result_sel;
    logic              mapped;
    logic              err;
    logic              wr_ok;
    logic [IDX_W-1:0]  lane_idx;

    assign pready = 1'b1;

    // A pending start counts as busy so no second access can slip in
    assign eng_busy = ctrl.busy | start_q;

    assign access     = psel & penable;
    assign aligned    = (paddr[1:0] == 2'b00);
    assign lane_idx   = paddr[2 +: IDX_W];
    assign seed_sel   = aligned &&
        (paddr[APB_ADDR_W-1:WIN_LSB] == SEED_BASE[APB_ADDR_W-1:WIN_LSB]);
    assign result_sel = aligned &&
        (paddr[APB_ADDR_W-1:WIN_LSB] == RESULT_BASE[APB_ADDR_W-1:WIN_LSB]);
    assign ctrl_sel   = (paddr == CTRL_ADDR);
    assign status_sel = (paddr == STATUS_ADDR);
    assign mapped     = seed_sel | ctrl_sel | status_sel | result_sel;

    assign err = access & (~mapped
                 | (pwrite & (status_sel | result_sel))
                 | (pwrite & eng_busy & (seed_sel | ctrl_sel)));

    assign pslverr = err;
    assign wr_ok   = access & pwrite & ~err;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seed_q   <= '{default: '0};
            result_q <= '{default: '0};
            start_q  <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            start_q <= wr_ok & ctrl_sel & pwdata[0];
            if (wr_ok && seed_sel) begin
                seed_q[lane_idx] <= pwdata;
            end
            if (ctrl.done) begin
                result_q <= ctrl.result;
                done_q   <= 1'b1;
            end else if (wr_ok && ctrl_sel && pwdata[0]) begin
                done_q <= 1'b0;
            end
        end
    end

    assign ctrl.start = start_q;
    assign ctrl.seed  = seed_q;

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            if (seed_sel) begin
                prdata = seed_q[lane_idx];
            end else if (result_sel) begin
                prdata = result_q[lane_idx];
            end else if (status_sel) begin
                prdata = word_t'({done_q, eng_busy});
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mix_core.sv
`timescale 1ns/10ps
`default_nettype none

module mix_core
    import mix_pkg::*;
#(
    parameter int MIX_ROUNDS   = 16,
    parameter int CHAIN_ROUNDS = 12
) (
    input  wire logic clk,
    input  wire logic arst_n,
    mix_ctrl_if.core  ctrl
);

    localparam int PROG_LEN  = 3 + 3 * MIX_ROUNDS + CHAIN_ROUNDS;
    localparam int CNT_W     = $clog2(PROG_LEN);
    localparam int MIX_LAST  = 3 * MIX_ROUNDS;
    localparam int CHAIN_END = MIX_LAST + CHAIN_ROUNDS;

    lanes_t           lanes_q;
    lanes_t           lanes_nxt;
    step_t            step;
    logic [CNT_W-1:0] cnt;
    logic             busy_q;
    logic             done_q;

    // Step 0 seeds, then the diffusion rounds, the chain steps and two scalings
    always_comb begin
        if (cnt == '0) begin
            step = STEP_SEED;
        end else if (cnt <= CNT_W'(MIX_LAST)) begin
            case ((cnt - CNT_W'(1)) % CNT_W'(3))
                CNT_W'(0): step = STEP_ADD_SUB;
                CNT_W'(1): step = STEP_XOR_SHL;
                default:   step = STEP_SHR_MIX;
            endcase
        end else if (cnt <= CNT_W'(CHAIN_END)) begin
            step = STEP_CHAIN;
        end else if (cnt == CNT_W'(CHAIN_END + 1)) begin
            step = STEP_SCALE_A;
        end else begin
            step = STEP_SCALE_B;
        end
    end

    mix_step_unit u_step (
        .lanes_in  (lanes_q),
        .step      (step),
        .lanes_out (lanes_nxt)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt    <= '0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (ctrl.start) begin
            cnt    <= '0;
            busy_q <= 1'b1;
            done_q <= 1'b0;
        end else if (done_q) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (busy_q) begin
            cnt <= cnt + CNT_W'(1);
            if (cnt == CNT_W'(PROG_LEN - 1)) begin
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.start) begin
            lanes_q <= ctrl.seed;
        end else if (busy_q && !done_q) begin
            lanes_q <= lanes_nxt;
        end
    end

    assign ctrl.busy   = busy_q;
    assign ctrl.done   = done_q;
    assign ctrl.result = lanes_q;

endmodule

`default_nettype wire

//--- logic/mix_step_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mix_step_unit
    import mix_pkg::*;
(
    input  wire lanes_t lanes_in,
    input  wire step_t  step,
    output lanes_t      lanes_out
);

    // Lanes are updated in order, and each one sees the lanes already
    // rewritten earlier in the same step
    always_comb begin
        lanes_t v;
        v = lanes_in;
        case (step)
            STEP_SEED: begin
                for (int i = 0; i < LANES; i++) begin
                    v[i] = v[i] + word_t'(i);
                end
                for (int i = 0; i < LANES; i++) begin
                    v[i] = v[i] + v[(i + LANES - 1) % LANES];
                end
            end
            STEP_ADD_SUB: begin
                for (int i = 0; i < LANES; i++) begin
                    v[i] = v[i] + v[(i + 1) % LANES] - v[(i + 5) % LANES];
                end
            end
            STEP_XOR_SHL: begin
                for (int i = 0; i < LANES; i++) begin
                    v[i] = v[i] ^ (v[(i + 3) % LANES] << XOR_SHL);
                end
            end
            STEP_SHR_MIX: begin
                for (int i = 0; i < LANES; i++) begin
                    v[i] = v[i] - (v[(i + 2) % LANES] >> SHR_SUB)
                                + (v[(i + 4) % LANES] >> SHR_ADD);
                end
            end
            STEP_CHAIN: begin
                for (int i = 0; i < LANES; i++) begin
                    v[i] = v[i] + v[(i + LANES - 1) % LANES]
                                - v[(i + LANES - 2) % LANES];
                end
            end
            STEP_SCALE_A: begin
                for (int i = 0; i < LANES; i++) begin
                    v[i] = v[i] * SCALE_A_MUL[i] + SCALE_A_ADD[i];
                end
            end
            STEP_SCALE_B: begin
                for (int i = 0; i < LANES; i++) begin
                    v[i] = v[i] * SCALE_B_MUL[i] + SCALE_B_ADD[i];
                end
            end
            default: begin
                v = lanes_in;
            end
        endcase
        lanes_out = v;
    end

endmodule

`default_nettype wire

//--- logic/mix_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mix_ctrl_if
    import mix_pkg::*;
();

    logic   start;
    lanes_t seed;
    logic   busy;
    logic   done;
    lanes_t result;

    modport regs (
        output start,
        output seed,
        input  busy,
        input  done,
        input  result
    );

    // The core only sees a start pulse and answers with busy and a done pulse
    modport core (
        input  start,
        input  seed,
        output busy,
        output done,
        output result
    );

endinterface

`default_nettype wire

//--- logic/mix_pkg.sv
`default_nettype none

package mix_pkg;

    localparam int LANES  = 8;
    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef word_t lanes_t [LANES];

    typedef enum logic [2:0] {
        STEP_SEED    = 3'd0,
        STEP_ADD_SUB = 3'd1,
        STEP_XOR_SHL = 3'd2,
        STEP_SHR_MIX = 3'd3,
        STEP_CHAIN   = 3'd4,
        STEP_SCALE_A = 3'd5,
        STEP_SCALE_B = 3'd6
    } step_t;

    // Shift amounts of the diffusion round
    localparam int XOR_SHL = 16;
    localparam int SHR_SUB = 17;
    localparam int SHR_ADD = 12;

    // Per-lane constants of the two closing multiply-add steps
    localparam lanes_t SCALE_A_MUL = '{32'd2, 32'd3, 32'd5, 32'd7,
                                       32'd11, 32'd13, 32'd17, 32'd19};
    localparam lanes_t SCALE_A_ADD = '{32'd3, 32'd5, 32'd7, 32'd11,
                                       32'd13, 32'd17, 32'd19, 32'd23};
    localparam lanes_t SCALE_B_MUL = '{32'd2, 32'd3, 32'd3, 32'd3,
                                       32'd5, 32'd13, 32'd35, 32'd87};
    localparam lanes_t SCALE_B_ADD = '{32'd0, 32'd1, 32'd8, 32'd27,
                                       32'd64, 32'd125, 32'd216, 32'd343};

    localparam int APB_ADDR_W = 8;

    // Byte offsets of the register map
    localparam logic [APB_ADDR_W-1:0] SEED_BASE   = 8'h00;
    localparam logic [APB_ADDR_W-1:0] CTRL_ADDR   = 8'h20;
    localparam logic [APB_ADDR_W-1:0] STATUS_ADDR = 8'h24;
    localparam logic [APB_ADDR_W-1:0] RESULT_BASE = 8'h40;

endpackage

`default_nettype wire
